/* src/mc_xlate_pkg.sv */
// remote address translation types
package mc_xlate_pkg;

  // mesh coordinate widths
  localparam int x_cord_width_gp = 4;
  localparam int y_cord_width_gp = 3;

  localparam int epa_width_gp           = 28; // endpoint physical address in words
  localparam int epa_word_addr_width_gp = 16; // word addr carried in global and tile-group eva
  localparam int data_width_gp          = 32; // data word and eva

  // global eva, top two bits read 01
  typedef struct packed {
    logic [1:0]                        remote;   // class field
    logic [5:0]                        y_cord;   // absolute y
    logic [5:0]                        x_cord;   // absolute x
    logic [epa_word_addr_width_gp-1:0] addr;     // word address
    logic [1:0]                        low_bits; // byte offset, dropped
  } global_addr_s;

  // tile-group eva, top three bits read 001
  typedef struct packed {
    logic [2:0]                        remote;   // class field
    logic [4:0]                        y_cord;   // y offset from origin
    logic [5:0]                        x_cord;   // x offset from origin
    logic [epa_word_addr_width_gp-1:0] addr;     // word address
    logic [1:0]                        low_bits; // byte offset, dropped
  } tile_group_addr_s;

  // network physical address
  typedef struct packed {
    logic [x_cord_width_gp-1:0] x_cord;
    logic [y_cord_width_gp-1:0] y_cord;
    logic [epa_width_gp-1:0]    epa;
  } npa_s;

  // outgoing mesh request
  typedef struct packed {
    npa_s                     npa;
    logic [data_width_gp-1:0] data; // store data
    logic                     we;   // write flag
  } remote_pkt_s;

  // software written translation config
  typedef struct packed {
    logic [x_cord_width_gp-1:0] tgo_x;       // tile-group origin x
    logic [y_cord_width_gp-1:0] tgo_y;       // tile-group origin y
    logic                       dram_enable; // striped dram mode
  } xlate_cfg_s;

endpackage

/* src/hash_function.sv */
// dram line to vcache bank hash
`timescale 1ns/100ps

module hash_function #(
  parameter int banks_p = 8,  // number of vcache banks, power of two
  parameter int sets_p  = 64  // sets per vcache
) (
  // cache line number, zero extended eva word address above the block offset
  input  logic [mc_xlate_pkg::data_width_gp-4:0] line_i,
  output logic [$clog2(banks_p)-1:0]             bank_o,  // {bot_not_top, x}
  output logic [$clog2(sets_p)-1:0]              index_o  // set within the bank
);

  localparam int lg_banks_lp = $clog2(banks_p);
  localparam int lg_sets_lp  = $clog2(sets_p);

  // field positions inside the line number
  localparam int index_lsb_lp = lg_banks_lp;              // index sits above bank bits
  localparam int upper_lsb_lp = lg_banks_lp + lg_sets_lp; // hash source above index

  logic [lg_banks_lp-1:0] bank_raw;   // plain interleave bits
  logic [lg_banks_lp-1:0] bank_upper; // bits just above the index field

  assign bank_raw   = line_i[0+:lg_banks_lp];
  assign bank_upper = line_i[upper_lsb_lp+:lg_banks_lp];

  // consecutive lines walk the banks in order,
  // while power-of-two strides get scrambled by the upper bits
  assign bank_o = bank_raw ^ bank_upper;

  // set index is untouched by the hash
  assign index_o = line_i[index_lsb_lp+:lg_sets_lp];

endmodule

/* src/eva_to_npa.sv */
// eva to network physical address
`timescale 1ns/100ps

module eva_to_npa #(
  parameter int num_tiles_x_p                = 4,
  parameter int vcache_block_size_in_words_p = 8,    // words per cache line
  parameter int vcache_size_p                = 1024, // vcache capacity in words
  parameter int vcache_sets_p                = 64
) (
  input  logic [mc_xlate_pkg::data_width_gp-1:0] eva_i, // byte address from the core
  input  mc_xlate_pkg::xlate_cfg_s               cfg_i,
  output mc_xlate_pkg::npa_s                     npa_o,
  output logic                                   is_invalid_addr_o
);

  import mc_xlate_pkg::*;

  localparam int block_offset_width_lp = $clog2(vcache_block_size_in_words_p);
  localparam int lg_vcache_size_lp     = $clog2(vcache_size_p);
  localparam int banks_lp              = num_tiles_x_p * 2; // top and bottom rows
  localparam int bank_width_lp         = $clog2(banks_lp);
  localparam int index_width_lp        = $clog2(vcache_sets_p);
  localparam int line_width_lp         = data_width_gp - 3; // eva bits 30..2
  localparam int line_lsb_lp           = 2 + block_offset_width_lp;

  global_addr_s     global_addr;
  tile_group_addr_s tile_group_addr;

  assign global_addr     = eva_i;
  assign tile_group_addr = eva_i;

  // eva class decode
  logic is_dram_addr;
  logic is_global_addr;
  logic is_tile_group_addr;

  assign is_dram_addr       = eva_i[data_width_gp-1];
  assign is_global_addr     = global_addr.remote == 2'b01;
  assign is_tile_group_addr = tile_group_addr.remote == 3'b001;

  // shared mem and local dmem fall through here
  assign is_invalid_addr_o = ~(is_dram_addr | is_global_addr | is_tile_group_addr);

  // dram striping
  logic [line_width_lp-1:0]  dram_line;
  logic [bank_width_lp-1:0]  hash_bank;
  logic [index_width_lp-1:0] hash_index;

  assign dram_line = line_width_lp'(eva_i[data_width_gp-2:line_lsb_lp]);

  hash_function #(
    .banks_p (banks_lp),
    .sets_p  (vcache_sets_p)
  ) hash_i (
    .line_i  (dram_line),
    .bank_o  (hash_bank),
    .index_o (hash_index)
  );

  always_comb begin
    npa_o = '0; // invalid eva leaves a zero npa
    if (is_dram_addr) begin
      if (cfg_i.dram_enable) begin
        // bank msb picks the bottom vcache row
        npa_o.y_cord = hash_bank[bank_width_lp-1] ? {y_cord_width_gp{1'b1}}
                                                  : {y_cord_width_gp{1'b0}};
        npa_o.x_cord = x_cord_width_gp'(hash_bank[bank_width_lp-2:0]);
        npa_o.epa    = epa_width_gp'({hash_index, eva_i[2+:block_offset_width_lp]});
      end else if (eva_i[data_width_gp-2]) begin
        // host memory behind the io port at (0,1)
        npa_o.y_cord = y_cord_width_gp'(1);
        npa_o.x_cord = '0;
        npa_o.epa    = {1'b1, eva_i[2+:epa_width_gp-1]};
      end else begin
        // vcache used as plain block memory
        npa_o.y_cord = eva_i[2+lg_vcache_size_lp+x_cord_width_gp] ? {y_cord_width_gp{1'b1}}
                                                                  : {y_cord_width_gp{1'b0}};
        npa_o.x_cord = eva_i[2+lg_vcache_size_lp+:x_cord_width_gp];
        npa_o.epa    = epa_width_gp'(eva_i[2+:lg_vcache_size_lp]);
      end
    end else if (is_global_addr) begin
      // coordinates carried directly in the eva
      npa_o.y_cord = y_cord_width_gp'(global_addr.y_cord);
      npa_o.x_cord = x_cord_width_gp'(global_addr.x_cord);
      npa_o.epa    = epa_width_gp'(global_addr.addr);
    end else if (is_tile_group_addr) begin
      // offset from tile-group origin, wraps at coord width
      npa_o.y_cord = y_cord_width_gp'(tile_group_addr.y_cord + cfg_i.tgo_y);
      npa_o.x_cord = x_cord_width_gp'(tile_group_addr.x_cord + cfg_i.tgo_x);
      npa_o.epa    = epa_width_gp'(tile_group_addr.addr);
    end
  end

endmodule

/* src/xlate_cfg_regs.sv */
// translation config registers
`timescale 1ns/100ps

module xlate_cfg_regs (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     cfg_we_i, // one cycle write strobe
  input  mc_xlate_pkg::xlate_cfg_s cfg_i,
  output mc_xlate_pkg::xlate_cfg_s cfg_o
);

  import mc_xlate_pkg::*;

  // origin at 0,0 and striped dram out of reset
  localparam xlate_cfg_s cfg_reset_lp = '{
    tgo_x:       '0,
    tgo_y:       '0,
    dram_enable: 1'b1
  };

  xlate_cfg_s cfg_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_r <= cfg_reset_lp;
    end else if (cfg_we_i) begin
      cfg_r <= cfg_i; // new value seen by next cycle's request
    end
  end

  assign cfg_o = cfg_r;

endmodule

/* src/remote_req_stage.sv */
// remote request output register
`timescale 1ns/100ps

module remote_req_stage (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   req_v_i,    // request strobe
  input  logic [mc_xlate_pkg::data_width_gp-1:0] req_data_i, // store data
  input  logic                                   req_we_i,
  input  mc_xlate_pkg::npa_s                     npa_i,      // translated address
  input  logic                                   is_invalid_i,
  output logic                                   out_v_o,    // packet valid pulse
  output mc_xlate_pkg::remote_pkt_s              out_pkt_o,
  output logic                                   err_o       // bad address pulse
);

  import mc_xlate_pkg::*;

  logic        send_v; // strobe with a mappable eva
  logic        bad_v;  // strobe with an unmapped eva
  logic        out_v_r;
  logic        err_r;
  remote_pkt_s pkt_r;

  assign send_v = req_v_i & ~is_invalid_i;
  assign bad_v  = req_v_i & is_invalid_i;

  // pulses, one cycle after the strobe
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_v_r <= 1'b0;
      err_r   <= 1'b0;
    end else begin
      out_v_r <= send_v;
      err_r   <= bad_v;
    end
  end

  // payload holds its last good packet
  always_ff @(posedge clk_i) begin
    if (send_v) begin
      pkt_r.npa  <= npa_i;
      pkt_r.data <= req_data_i;
      pkt_r.we   <= req_we_i;
    end
  end

  assign out_v_o   = out_v_r;
  assign out_pkt_o = pkt_r;
  assign err_o     = err_r;

endmodule

/* src/mc_xlate_top.sv */
// remote port address translation front
`timescale 1ns/100ps

module mc_xlate_top #(
  parameter int num_tiles_x_p                = 4,
  parameter int vcache_block_size_in_words_p = 8,
  parameter int vcache_size_p                = 1024, // words
  parameter int vcache_sets_p                = 64
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   cfg_we_i,
  input  mc_xlate_pkg::xlate_cfg_s               cfg_i,
  input  logic                                   req_v_i,
  input  logic [mc_xlate_pkg::data_width_gp-1:0] req_eva_i,  // byte address
  input  logic [mc_xlate_pkg::data_width_gp-1:0] req_data_i,
  input  logic                                   req_we_i,
  output logic                                   out_v_o,
  output mc_xlate_pkg::remote_pkt_s              out_pkt_o,
  output logic                                   err_o
);

  import mc_xlate_pkg::*;

  xlate_cfg_s cfg;        // live config
  npa_s       npa;        // combinational translation
  logic       is_invalid; // eva has no remote mapping

  xlate_cfg_regs cfg_regs_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .cfg_we_i (cfg_we_i),
    .cfg_i    (cfg_i),
    .cfg_o    (cfg)
  );

  eva_to_npa #(
    .num_tiles_x_p                (num_tiles_x_p),
    .vcache_block_size_in_words_p (vcache_block_size_in_words_p),
    .vcache_size_p                (vcache_size_p),
    .vcache_sets_p                (vcache_sets_p)
  ) eva_to_npa_i (
    .eva_i             (req_eva_i),
    .cfg_i             (cfg),
    .npa_o             (npa),
    .is_invalid_addr_o (is_invalid)
  );

  remote_req_stage req_stage_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_v_i      (req_v_i),
    .req_data_i   (req_data_i),
    .req_we_i     (req_we_i),
    .npa_i        (npa),
    .is_invalid_i (is_invalid),
    .out_v_o      (out_v_o),
    .out_pkt_o    (out_pkt_o),
    .err_o        (err_o)
  );

endmodule

/* dv/tb_clk_gen.sv */
// testbench clock and reset
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int reset_cycles_p = 3
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o   = 1'b0;
    reset_o = 1'b1; // held from time zero
    repeat (reset_cycles_p) @(posedge clk_o);
    reset_o <= 1'b0;
  end

  always #2 clk_o = ~clk_o; // 4 ns period

endmodule

/* dv/mc_xlate_props.sv */
// translation checker properties
`timescale 1ns/100ps

module mc_xlate_props #(
  parameter int num_tiles_x_p                = 4,
  parameter int vcache_block_size_in_words_p = 8,
  parameter int vcache_size_p                = 1024,
  parameter int vcache_sets_p                = 64
) (
  input logic                                   clk_i,
  input logic                                   reset_i,
  input logic                                   cfg_we_i,
  input mc_xlate_pkg::xlate_cfg_s               cfg_i,
  input logic                                   req_v_i,
  input logic [mc_xlate_pkg::data_width_gp-1:0] req_eva_i,
  input logic [mc_xlate_pkg::data_width_gp-1:0] req_data_i,
  input logic                                   req_we_i,
  input logic                                   out_v_o,
  input mc_xlate_pkg::remote_pkt_s              out_pkt_o,
  input logic                                   err_o
);

  import mc_xlate_pkg::*;

  localparam int bo_lp      = $clog2(vcache_block_size_in_words_p); // word in line
  localparam int lg_bank_lp = $clog2(2 * num_tiles_x_p);
  localparam int lg_set_lp  = $clog2(vcache_sets_p);
  localparam int lg_vc_lp   = $clog2(vcache_size_p);

  xlate_cfg_s  cfg_q;   // shadow of the config register
  remote_pkt_s exp_pkt; // packet the current eva should give
  logic        exp_bad;
  int          fail_cnt = 0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_q <= '{tgo_x: '0, tgo_y: '0, dram_enable: 1'b1};
    end else if (cfg_we_i) begin
      cfg_q <= cfg_i;
    end
  end

  // reference mapping
  always_comb begin
    logic [31:0]           line;
    logic [lg_bank_lp-1:0] bank;
    logic [lg_set_lp-1:0]  set;
    line         = 32'(req_eva_i[30:2]) >> bo_lp; // dram line number
    bank         = line[lg_bank_lp-1:0] ^ line[lg_bank_lp+lg_set_lp+:lg_bank_lp];
    set          = line[lg_bank_lp+:lg_set_lp];
    exp_bad      = 1'b0;
    exp_pkt      = '0;
    exp_pkt.data = req_data_i;
    exp_pkt.we   = req_we_i;
    casez (req_eva_i[31:29])
      3'b1??: begin
        if (cfg_q.dram_enable) begin
          exp_pkt.npa.y_cord = {y_cord_width_gp{bank[lg_bank_lp-1]}};
          exp_pkt.npa.x_cord = x_cord_width_gp'(bank[lg_bank_lp-2:0]);
          exp_pkt.npa.epa    = epa_width_gp'({set, req_eva_i[2+:bo_lp]});
        end else if (req_eva_i[30]) begin
          exp_pkt.npa.y_cord = y_cord_width_gp'(1); // host port
          exp_pkt.npa.epa    = {1'b1, req_eva_i[28:2]};
        end else begin
          exp_pkt.npa.y_cord = {y_cord_width_gp{req_eva_i[2+lg_vc_lp+x_cord_width_gp]}};
          exp_pkt.npa.x_cord = req_eva_i[2+lg_vc_lp+:x_cord_width_gp];
          exp_pkt.npa.epa    = epa_width_gp'(req_eva_i[2+:lg_vc_lp]);
        end
      end
      3'b01?: begin // global, upper coord bits dropped
        exp_pkt.npa.y_cord = req_eva_i[26:24];
        exp_pkt.npa.x_cord = req_eva_i[21:18];
        exp_pkt.npa.epa    = epa_width_gp'(req_eva_i[17:2]);
      end
      3'b001: begin // low bits of the sum only
        exp_pkt.npa.y_cord = req_eva_i[26:24] + cfg_q.tgo_y;
        exp_pkt.npa.x_cord = req_eva_i[21:18] + cfg_q.tgo_x;
        exp_pkt.npa.epa    = epa_width_gp'(req_eva_i[17:2]);
      end
      default: exp_bad = 1'b1; // shared and local
    endcase
  end

  quiet_after_reset: assert property (@(posedge clk_i)
    $past(reset_i) |-> !out_v_o && !err_o)
    else begin
      fail_cnt++;
      $error("a pulse came out during reset or the cycle after it");
    end

  one_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_i |=> out_v_o ^ err_o)
    else begin
      fail_cnt++;
      $error("a strobe did not give exactly one pulse in the next cycle");
    end

  no_stray_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    !req_v_i |=> !out_v_o && !err_o)
    else begin
      fail_cnt++;
      $error("a pulse came out with no strobe before it");
    end

  packet_match: assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_i && !exp_bad |=> out_v_o && out_pkt_o === $past(exp_pkt))
    else begin
      fail_cnt++;
      $error("Error at %0t: wrong packet %h", $time, out_pkt_o);
    end

  error_match: assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_i && exp_bad |=> err_o && !out_v_o && out_pkt_o === $past(out_pkt_o))
    else begin
      fail_cnt++;
      $error("Error at %0t: bad eva not flagged or packet %h changed", $time, out_pkt_o);
    end

endmodule

bind mc_xlate_top mc_xlate_props #(
  .num_tiles_x_p                (num_tiles_x_p),
  .vcache_block_size_in_words_p (vcache_block_size_in_words_p),
  .vcache_size_p                (vcache_size_p),
  .vcache_sets_p                (vcache_sets_p)
) props_i (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .cfg_we_i   (cfg_we_i),
  .cfg_i      (cfg_i),
  .req_v_i    (req_v_i),
  .req_eva_i  (req_eva_i),
  .req_data_i (req_data_i),
  .req_we_i   (req_we_i),
  .out_v_o    (out_v_o),
  .out_pkt_o  (out_pkt_o),
  .err_o      (err_o)
);

/* dv/mc_xlate_tb.sv */
// translation front testbench
`timescale 1ns/100ps

module mc_xlate_tb;

  import mc_xlate_pkg::*;

  localparam int n_burst_lp = 40;            // requests per burst
  localparam int n_req_lp   = 6 * n_burst_lp; // six bursts
  localparam int timeout_lp = n_req_lp + 64;  // reset, cfg writes, drains

  logic        clk;
  logic        reset;
  logic        cfg_we;
  xlate_cfg_s  cfg;
  logic        req_v;
  logic [31:0] req_eva;
  logic [31:0] req_data;
  logic        req_we;
  logic        out_v;
  remote_pkt_s out_pkt;
  logic        err;

  logic [31:0] lfsr_q    = 32'd58; // seed
  int          cycle_cnt = 0;
  int          tests_run = 0;
  int          tests_bad = 0;

  tb_clk_gen clk_gen_i (
    .clk_o   (clk),
    .reset_o (reset)
  );

  mc_xlate_top #(
    .num_tiles_x_p                (4),
    .vcache_block_size_in_words_p (8),
    .vcache_size_p                (1024),
    .vcache_sets_p                (64)
  ) dut_i (
    .clk_i      (clk),
    .reset_i    (reset),
    .cfg_we_i   (cfg_we),
    .cfg_i      (cfg),
    .req_v_i    (req_v),
    .req_eva_i  (req_eva),
    .req_data_i (req_data),
    .req_we_i   (req_we),
    .out_v_o    (out_v),
    .out_pkt_o  (out_pkt),
    .err_o      (err)
  );

  // x^32 + x^22 + x^2 + x + 1, right shifting
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      v      = {v[30:0], lfsr_q[0]}; // one step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic send_req(input logic [31:0] eva);
    logic [31:0] d;
    logic [31:0] w;
    rand_bits(32, d);
    rand_bits(1, w);
    @(posedge clk);
    req_v    <= 1'b1;
    req_eva  <= eva;
    req_data <= d;
    req_we   <= w[0];
  endtask

  task automatic write_cfg(input xlate_cfg_s c);
    @(posedge clk);
    cfg_we <= 1'b1;
    cfg    <= c;
    @(posedge clk);
    cfg_we <= 1'b0;
  endtask

  task automatic report_test(input string name, input int n, input int fails_before);
    int f;
    f = dut_i.props_i.fail_cnt - fails_before;
    tests_run++;
    if (f != 0) tests_bad++;
    $display("test %-12s %0d requests, %0d assertion failures", name, n, f);
  endtask

  // back-to-back strobes, eva top bits fixed, rest random
  task automatic run_burst(input string name, input logic [2:0] top, input int top_w);
    int          fails_before;
    logic [31:0] r;
    fails_before = dut_i.props_i.fail_cnt;
    repeat (n_burst_lp) begin
      rand_bits(32 - top_w, r);
      send_req((32'(top) << (32 - top_w)) | r);
    end
    @(posedge clk);
    req_v <= 1'b0;
    @(posedge clk); // last pulse sampled
    @(negedge clk); // its assertion has settled by now
    report_test(name, n_burst_lp, fails_before);
  endtask

  initial begin
    logic [31:0] r;
    xlate_cfg_s  c;
    cfg_we   = 1'b0;
    cfg      = '0;
    req_v    = 1'b0;
    req_eva  = '0;
    req_data = '0;
    req_we   = 1'b0;
    while (reset !== 1'b0) @(posedge clk);
    @(posedge clk); // quiet cycle after reset
    report_test("reset", 0, 0);
    run_burst("global", 3'b01, 2);
    rand_bits(7, r);
    c = '{tgo_x: r[3:0], tgo_y: r[6:4], dram_enable: 1'b1};
    write_cfg(c);
    run_burst("tile_group", 3'b001, 3);
    run_burst("dram_hash", 3'b1, 1);
    c.dram_enable = 1'b0;
    write_cfg(c);
    run_burst("host", 3'b11, 2);
    run_burst("block_mem", 3'b10, 2);
    run_burst("invalid", 3'b000, 3);
    repeat (2) @(posedge clk);
    $display("%0d tests, %0d failed, %0d assertion failures",
             tests_run, tests_bad, dut_i.props_i.fail_cnt);
    if (tests_bad == 0 && dut_i.props_i.fail_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_lp) begin
      $display("timeout: tests still running after %0d cycles", cycle_cnt);
      $display("FAIL: see errors above");
      $finish;
    end
  end

endmodule

/* mc_xlate.f */
src/mc_xlate_pkg.sv
src/hash_function.sv
src/eva_to_npa.sv
src/xlate_cfg_regs.sv
src/remote_req_stage.sv
src/mc_xlate_top.sv
dv/tb_clk_gen.sv
dv/mc_xlate_props.sv
dv/mc_xlate_tb.sv

/* Bender.yml */
package:
  name: mc_xlate

sources:
  - src/mc_xlate_pkg.sv
  - src/hash_function.sv
  - src/eva_to_npa.sv
  - src/xlate_cfg_regs.sv
  - src/remote_req_stage.sv
  - src/mc_xlate_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/mc_xlate_props.sv
      - dv/mc_xlate_tb.sv
